// File: source/memwrap_pkg.sv
package memwrap_pkg;

  // logical word and physical row geometry
  localparam int word_w        = 16;
  localparam int words_per_row = 3;
  localparam int num_rows      = 64;
  localparam int num_addr      = words_per_row * num_rows;

  localparam int addr_w     = $clog2(num_addr);
  localparam int row_w      = $clog2(num_rows);
  localparam int slot_w     = $clog2(words_per_row);
  localparam int row_data_w = words_per_row * word_w;

  // cycles from sram port to returned row
  localparam int sram_delay = 2;

  localparam int cfg_w = 16;

  typedef struct packed {
    logic              write;
    logic [addr_w-1:0] addr;
    logic [word_w-1:0] mask;
    logic [word_w-1:0] data;
  } wr_cmd_t;

  typedef struct packed {
    logic              read;
    logic [addr_w-1:0] addr;
  } rd_cmd_t;

  typedef struct packed {
    logic                  en;
    logic [row_w-1:0]      row;
    logic [row_data_w-1:0] mask;
    logic [row_data_w-1:0] data;
  } mem_wr_t;

  typedef struct packed {
    logic             en;
    logic [row_w-1:0] row;
  } mem_rd_t;

  // fwd_en sits in bit 0 of the control register
  typedef struct packed {
    logic psdo_en;
    logic fwd_en;
  } cfg_ctrl_t;

endpackage

// File: source/addr_split.sv
`timescale 1ns/100ps

module addr_split (
  input  logic [memwrap_pkg::addr_w-1:0] addr,
  output logic [memwrap_pkg::row_w-1:0]  row,
  output logic [memwrap_pkg::slot_w-1:0] slot
);

  import memwrap_pkg::*;

  localparam logic [addr_w-1:0] div_const = addr_w'(words_per_row);

  logic [addr_w-1:0] quot;
  logic [addr_w-1:0] rem;

  // words per row is 3, so a true divide is needed
  always_comb begin
    quot = addr / div_const;
    rem  = addr % div_const;
  end

  // quotient stays below num_rows for any legal address
  assign row  = row_w'(quot);
  assign slot = slot_w'(rem);

endmodule

// File: source/wide_sram.sv
`timescale 1ns/100ps

module wide_sram (
  input  logic                               clk,
  input  memwrap_pkg::mem_wr_t               mem_wr,
  input  memwrap_pkg::mem_rd_t               mem_rd,
  output logic [memwrap_pkg::row_data_w-1:0] mem_dout
);

  import memwrap_pkg::*;

  logic [row_data_w-1:0] mem      [num_rows];
  logic [row_data_w-1:0] rd_stage [sram_delay];

  // bit-masked row update
  always_ff @(posedge clk) begin
    if (mem_wr.en) begin
      mem[mem_wr.row] <= (mem[mem_wr.row] & ~mem_wr.mask) | (mem_wr.data & mem_wr.mask);
    end
  end

  // read sees the row before a same-edge write lands
  always_ff @(posedge clk) begin
    if (mem_rd.en) begin
      rd_stage[0] <= mem[mem_rd.row];
    end
    for (int i = 1; i < sram_delay; i++) begin
      rd_stage[i] <= rd_stage[i-1];
    end
  end

  assign mem_dout = rd_stage[sram_delay-1];

endmodule

// File: source/wrap_cfg.sv
`timescale 1ns/100ps

module wrap_cfg (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          cfg_req,
  input  logic                          cfg_we,
  input  logic                          cfg_sel,
  input  logic [memwrap_pkg::cfg_w-1:0] cfg_wdata,
  output logic                          cfg_ack,
  output logic [memwrap_pkg::cfg_w-1:0] cfg_rdata,
  input  logic                          fwd_hit,
  output memwrap_pkg::cfg_ctrl_t        ctrl
);

  import memwrap_pkg::*;

  typedef enum logic {
    st_idle,
    st_ack
  } cfg_state_t;

  cfg_state_t       state;
  logic             access;
  logic [cfg_w-1:0] fwd_cnt;

  // one access per request, on the idle to ack edge
  assign access  = (state == st_idle) && cfg_req;
  assign cfg_ack = (state == st_ack);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: if (cfg_req) state <= st_ack;
        st_ack:  if (!cfg_req) state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl <= '0;
    end else if (access && cfg_we && !cfg_sel) begin
      ctrl <= cfg_ctrl_t'(cfg_wdata[$bits(cfg_ctrl_t)-1:0]);
    end
  end

  // saturating forward count
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fwd_cnt <= '0;
    end else if (fwd_hit && (fwd_cnt != '1)) begin
      fwd_cnt <= fwd_cnt + 1'b1;
    end
  end

  // read data held for the whole ack phase
  always_ff @(posedge clk) begin
    if (access && !cfg_we) begin
      cfg_rdata <= cfg_sel ? fwd_cnt : cfg_w'(ctrl);
    end
  end

  a_ack_needs_req: assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(cfg_ack) |-> cfg_req
  );

endmodule

// File: source/align_ramwrap.sv
`timescale 1ns/100ps

module align_ramwrap (
  input  logic                               clk,
  input  logic                               rst_n,
  input  memwrap_pkg::wr_cmd_t               wr,
  input  memwrap_pkg::rd_cmd_t               rd,
  input  memwrap_pkg::cfg_ctrl_t             ctrl,
  output memwrap_pkg::mem_wr_t               mem_wr,
  output memwrap_pkg::mem_rd_t               mem_rd,
  input  logic [memwrap_pkg::row_data_w-1:0] mem_dout,
  output logic                               rd_vld,
  output logic [memwrap_pkg::word_w-1:0]     rd_dout,
  output logic                               fwd_hit
);

  import memwrap_pkg::*;

  // per-read state carried alongside the sram access
  typedef struct packed {
    logic              fwd;
    logic [slot_w-1:0] slot;
    logic [word_w-1:0] data;
  } rd_tag_t;

  wr_cmd_t wr_q;
  rd_cmd_t rd_q;

  logic [row_w-1:0]  wr_row;
  logic [slot_w-1:0] wr_slot;
  logic [row_w-1:0]  rd_row;
  logic [slot_w-1:0] rd_slot;

  logic [sram_delay-1:0] vld_pipe;
  rd_tag_t               tag_pipe [sram_delay];
  rd_tag_t               tag_out;
  logic [row_data_w-1:0] row_shift;

  // command input registers
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_q.write <= 1'b0;
      rd_q.read  <= 1'b0;
    end else begin
      wr_q.write <= wr.write;
      rd_q.read  <= rd.read;
      if (wr.write) begin
        wr_q.addr <= wr.addr;
        wr_q.mask <= wr.mask;
        wr_q.data <= wr.data;
      end
      if (rd.read) begin
        rd_q.addr <= rd.addr;
      end
    end
  end

  addr_split i_wr_split (
    .addr (wr_q.addr),
    .row  (wr_row),
    .slot (wr_slot)
  );

  addr_split i_rd_split (
    .addr (rd_q.addr),
    .row  (rd_row),
    .slot (rd_slot)
  );

  // same-cycle collision on the full logical address
  assign fwd_hit = ctrl.fwd_en && rd_q.read && wr_q.write && (rd_q.addr == wr_q.addr);

  always_comb begin
    mem_wr.en   = wr_q.write;
    mem_wr.row  = wr_row;
    mem_wr.mask = row_data_w'(wr_q.mask) << (wr_slot * word_w);
    mem_wr.data = row_data_w'(wr_q.data) << (wr_slot * word_w);
    // forwarded reads need no array access when psdo_en is set
    mem_rd.en   = rd_q.read && !(ctrl.psdo_en && fwd_hit);
    mem_rd.row  = rd_row;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe <= {vld_pipe[sram_delay-2:0], rd_q.read};
    end
  end

  always_ff @(posedge clk) begin
    tag_pipe[0].fwd  <= fwd_hit;
    tag_pipe[0].slot <= rd_slot;
    tag_pipe[0].data <= wr_q.data;
    for (int i = 1; i < sram_delay; i++) begin
      tag_pipe[i] <= tag_pipe[i-1];
    end
  end

  // narrow the returned row back to one word
  assign tag_out   = tag_pipe[sram_delay-1];
  assign row_shift = mem_dout >> (tag_out.slot * word_w);

  assign rd_vld  = vld_pipe[sram_delay-1];
  assign rd_dout = tag_out.fwd ? tag_out.data : row_shift[word_w-1:0];

  a_rd_addr_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    rd_q.read |-> (rd_q.addr < num_addr)
  );

  a_rd_dout_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    rd_vld |-> !$isunknown(rd_dout)
  );

endmodule

// File: source/memwrap_top.sv
`timescale 1ns/100ps

module memwrap_top (
  input  logic                          clk,
  input  logic                          rst_n,
  input  memwrap_pkg::wr_cmd_t          wr,
  input  memwrap_pkg::rd_cmd_t          rd,
  output logic                          rd_vld,
  output logic [memwrap_pkg::word_w-1:0] rd_dout,
  input  logic                          cfg_req,
  input  logic                          cfg_we,
  input  logic                          cfg_sel,
  input  logic [memwrap_pkg::cfg_w-1:0] cfg_wdata,
  output logic                          cfg_ack,
  output logic [memwrap_pkg::cfg_w-1:0] cfg_rdata
);

  import memwrap_pkg::*;

  cfg_ctrl_t             ctrl;
  logic                  fwd_hit;
  mem_wr_t               mem_wr;
  mem_rd_t               mem_rd;
  logic [row_data_w-1:0] mem_dout;

  wrap_cfg i_cfg (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg_req   (cfg_req),
    .cfg_we    (cfg_we),
    .cfg_sel   (cfg_sel),
    .cfg_wdata (cfg_wdata),
    .cfg_ack   (cfg_ack),
    .cfg_rdata (cfg_rdata),
    .fwd_hit   (fwd_hit),
    .ctrl      (ctrl)
  );

  align_ramwrap i_wrap (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr       (wr),
    .rd       (rd),
    .ctrl     (ctrl),
    .mem_wr   (mem_wr),
    .mem_rd   (mem_rd),
    .mem_dout (mem_dout),
    .rd_vld   (rd_vld),
    .rd_dout  (rd_dout),
    .fwd_hit  (fwd_hit)
  );

  wide_sram i_sram (
    .clk      (clk),
    .mem_wr   (mem_wr),
    .mem_rd   (mem_rd),
    .mem_dout (mem_dout)
  );

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
  output logic clk,
  output logic rst_n
);

  localparam int half_period  = 2;
  localparam int reset_cycles = 4;

  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

  // release on a rising edge, like the rest of the stimulus
  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

// File: bench/memwrap_tb.sv
`timescale 1ns/100ps

module memwrap_tb;

  import memwrap_pkg::*;

  localparam int clk_period  = 4;
  localparam int rand_ops    = 600;
  localparam int coll_ops    = 48;
  localparam int slack       = 200;
  localparam int test_cycles = 2 * num_addr + rand_ops + 3 * coll_ops + slack;
  localparam int wait_limit  = 16;

  // expected read result and the cycle it must appear in
  typedef struct packed {
    logic [31:0]       due;
    logic [word_w-1:0] data;
  } exp_rd_t;

  logic              clk;
  logic              rst_n;
  wr_cmd_t           wr;
  rd_cmd_t           rd;
  logic              rd_vld;
  logic [word_w-1:0] rd_dout;
  logic              cfg_req;
  logic              cfg_we;
  logic              cfg_sel;
  logic [cfg_w-1:0]  cfg_wdata;
  logic              cfg_ack;
  logic [cfg_w-1:0]  cfg_rdata;

  logic [word_w-1:0] model [num_addr];
  exp_rd_t           exp_q [$];
  exp_rd_t           got;
  int                got_cnt = 0;
  logic [31:0]       cyc = '0;
  logic [31:0]       seed;
  logic [1:0]        ctrl_m;
  int                fwd_count;

  tb_clock i_clock (
    .clk   (clk),
    .rst_n (rst_n)
  );

  memwrap_top i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr        (wr),
    .rd        (rd),
    .rd_vld    (rd_vld),
    .rd_dout   (rd_dout),
    .cfg_req   (cfg_req),
    .cfg_we    (cfg_we),
    .cfg_sel   (cfg_sel),
    .cfg_wdata (cfg_wdata),
    .cfg_ack   (cfg_ack),
    .cfg_rdata (cfg_rdata)
  );

  always @(posedge clk) begin
    cyc <= cyc + 32'd1;
  end

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [addr_w-1:0] pick_addr(input logic [31:0] s);
    return addr_w'(s[31:16] % num_addr);
  endfunction

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at %0t", $time);
  endtask

  task automatic check_value(input string name, input logic [31:0] act,
                             input logic [31:0] exp);
    if (act !== exp) begin
      fail_stop($sformatf("Fail at %0t: %s is %h, expected %h", $time, name, act, exp));
    end
  endtask

  // one command cycle, model updated read-before-write
  task automatic issue(input wr_cmd_t w, input rd_cmd_t r);
    exp_rd_t e;
    @(posedge clk);
    wr <= w;
    rd <= r;
    if (r.read) begin
      e.due = cyc + 32'd4;
      if (ctrl_m[0] && w.write && (w.addr == r.addr)) begin
        e.data = w.data;
        fwd_count++;
      end else begin
        e.data = model[r.addr];
      end
      exp_q.push_back(e);
    end
    if (w.write) begin
      model[w.addr] = (model[w.addr] & ~w.mask) | (w.data & w.mask);
    end
  endtask

  task automatic drain();
    int n;
    @(posedge clk);
    wr <= '0;
    rd <= '0;
    n = 0;
    while (got_cnt < exp_q.size()) begin
      @(posedge clk);
      n++;
      if (n > wait_limit) begin
        fail_stop("reads still outstanding long after the last command");
      end
    end
  endtask

  task automatic random_traffic(input int n);
    wr_cmd_t w;
    rd_cmd_t r;
    for (int i = 0; i < n; i++) begin
      seed = lcg(seed);
      w.write = seed[31];
      w.addr  = pick_addr(seed);
      w.mask  = seed[15:0];
      seed = lcg(seed);
      w.data  = seed[31:16];
      r.read  = seed[15] | seed[14];
      seed = lcg(seed);
      r.addr  = pick_addr(seed);
      issue(w, r);
    end
  endtask

  task automatic readback_all();
    wr_cmd_t w;
    rd_cmd_t r;
    w = '0;
    for (int a = 0; a < num_addr; a++) begin
      r.read = 1'b1;
      r.addr = addr_w'(a);
      issue(w, r);
    end
  endtask

  // mostly same-address pairs, now and then a read elsewhere
  task automatic collide(input int n);
    wr_cmd_t w;
    rd_cmd_t r;
    for (int i = 0; i < n; i++) begin
      seed = lcg(seed);
      w.write = 1'b1;
      w.addr  = pick_addr(seed);
      w.mask  = seed[15:0];
      seed = lcg(seed);
      w.data  = seed[31:16];
      r.read  = 1'b1;
      r.addr  = (seed[2:0] == 3'd0) ? pick_addr(lcg(seed)) : w.addr;
      issue(w, r);
    end
  endtask

  // four-phase req/ack access
  task automatic cfg_access(input logic we, input logic sel, input logic [cfg_w-1:0] wdata,
                            output logic [cfg_w-1:0] rdata);
    int n;
    @(posedge clk);
    cfg_req   <= 1'b1;
    cfg_we    <= we;
    cfg_sel   <= sel;
    cfg_wdata <= wdata;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > wait_limit) begin
        fail_stop("cfg_ack never rose after cfg_req");
      end
    end while (cfg_ack !== 1'b1);
    rdata = cfg_rdata;
    @(posedge clk);
    cfg_req <= 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > wait_limit) begin
        fail_stop("cfg_ack never fell after cfg_req dropped");
      end
    end while (cfg_ack !== 1'b0);
  endtask

  task automatic cfg_expect(input logic sel, input logic [31:0] exp, input string name);
    logic [cfg_w-1:0] rdata;
    cfg_access(1'b0, sel, '0, rdata);
    check_value(name, 32'(rdata), exp);
  endtask

  task automatic set_ctrl(input logic [1:0] v);
    logic [cfg_w-1:0] rdata;
    cfg_access(1'b1, 1'b0, cfg_w'(v), rdata);
    ctrl_m = v;
    cfg_expect(1'b0, 32'(v), "cfg_rdata ctrl");
  endtask

  // every rd_vld matched in order against its due cycle
  always @(negedge clk) begin
    if (rst_n === 1'b1) begin
      if (rd_vld === 1'b1) begin
        if (got_cnt >= exp_q.size()) begin
          fail_stop("rd_vld was high with no read outstanding");
        end else begin
          got = exp_q[got_cnt];
          check_value("rd_vld cycle", cyc, got.due);
          check_value("rd_dout", 32'(rd_dout), 32'(got.data));
          got_cnt = got_cnt + 1;
        end
      end else begin
        check_value("rd_vld", 32'(rd_vld), 32'd0);
        if (got_cnt < exp_q.size() && exp_q[got_cnt].due == cyc) begin
          fail_stop("rd_vld stayed low in the cycle a read was due");
        end
      end
    end
  end

  initial begin
    #(test_cycles * clk_period + 400);
    fail_stop("watchdog expired before the tests completed");
  end

  initial begin
    wr_cmd_t w;
    rd_cmd_t r;
    wr        = '0;
    rd        = '0;
    cfg_req   = 1'b0;
    cfg_we    = 1'b0;
    cfg_sel   = 1'b0;
    cfg_wdata = '0;
    seed      = 32'hf907_1248;
    ctrl_m    = 2'b00;
    fwd_count = 0;
    wait (rst_n === 1'b1);

    cfg_expect(1'b0, 32'd0, "cfg_rdata ctrl");
    cfg_expect(1'b1, 32'd0, "cfg_rdata fwd_cnt");
    repeat (8) @(posedge clk);

    // full-mask fill so every model word is known
    r = '0;
    for (int a = 0; a < num_addr; a++) begin
      seed = lcg(seed);
      w.write = 1'b1;
      w.addr  = addr_w'(a);
      w.mask  = '1;
      w.data  = seed[31:16];
      issue(w, r);
    end
    drain();

    random_traffic(rand_ops);
    drain();
    readback_all();
    drain();

    // no forwarding, old word comes back
    collide(coll_ops);
    drain();
    cfg_expect(1'b1, 32'(fwd_count), "cfg_rdata fwd_cnt");

    set_ctrl(2'b01);
    collide(coll_ops);
    drain();
    cfg_expect(1'b1, 32'(fwd_count), "cfg_rdata fwd_cnt");

    // forwarding with the sram read suppressed
    set_ctrl(2'b11);
    collide(coll_ops);
    drain();
    cfg_expect(1'b1, 32'(fwd_count), "cfg_rdata fwd_cnt");

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// File: memwrap.f
source/memwrap_pkg.sv
source/addr_split.sv
source/wide_sram.sv
source/wrap_cfg.sv
source/align_ramwrap.sv
source/memwrap_top.sv
bench/tb_clock.sv
bench/memwrap_tb.sv

// File: run_sim.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert \
  --top-module memwrap_tb \
  -f memwrap.f \
  --Mdir "$build_dir" -o memwrap_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$build_dir/memwrap_sim" > "$log_file" 2>&1
run_status=$?
cat "$log_file"

if grep -q "Simulation finished: FAIL" "$log_file"; then
  echo "testbench reported a failure"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

echo "run complete, see $log_file"
exit 0
